// ==== Makefile ====
TOP  = twiddle_store_tb
SRCS = $(filter-out +incdir+%,$(shell cat list.f))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(wildcard verification/*.svh) list.f
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f list.f --top-module $(TOP) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// ==== list.f ====
+incdir+verification
src/twiddle_pkg.sv
src/twiddle_base_bank.sv
src/twiddle_const_table.sv
src/twiddle_store.sv
verification/twiddle_store_tb.sv

// ==== src/twiddle_base_bank.sv ====
`timescale 1ns/1ns

module twiddle_base_bank (
    input  logic                                                        clk,
    input  logic                                                        rst,
    input  logic                                                        tf_ren,
    input  logic                                                        tf_wen,
    input  logic [twiddle_pkg::depth_bits-1:0]                          rd_depth,
    input  logic [twiddle_pkg::depth_bits-1:0]                          wr_depth,
    input  logic [twiddle_pkg::tf_lanes-1:0][twiddle_pkg::tf_width-1:0] wr_base,
    output logic [twiddle_pkg::tf_lanes-1:0][twiddle_pkg::tf_width-1:0] rd_base
);

    logic [twiddle_pkg::tf_width-1:0] base_mem [twiddle_pkg::tf_depth][twiddle_pkg::tf_lanes];
    logic [twiddle_pkg::tf_lanes-1:0][twiddle_pkg::tf_width-1:0] rd_row;

    // Whole-row write, table reloaded on reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base_mem <= twiddle_pkg::base_init;
        end else if (tf_wen) begin
            for (int l = 0; l < twiddle_pkg::tf_lanes; l++) begin
                base_mem[wr_depth][l] <= wr_base[l];
            end
        end
    end

    // Row addressed by the read port, before any write at this edge
    always_comb begin
        for (int l = 0; l < twiddle_pkg::tf_lanes; l++) begin
            rd_row[l] = base_mem[rd_depth][l];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_base <= '0;
        end else if (tf_ren) begin
            rd_base <= rd_row;                // Holds while no read
        end
    end

endmodule

// ==== src/twiddle_const_table.sv ====
`timescale 1ns/1ns

module twiddle_const_table (
    input  logic                                                              clk,
    input  logic                                                              rst,
    input  logic                                                              tf_ren,
    input  logic [twiddle_pkg::tf_lanes-1:0][twiddle_pkg::const_idx_bits-1:0] const_idx,
    output logic [twiddle_pkg::tf_lanes-1:0][twiddle_pkg::tf_width-1:0]       rd_const
);

    logic [twiddle_pkg::tf_width-1:0] const_mem [twiddle_pkg::const_entries];
    logic [twiddle_pkg::tf_lanes-1:0][twiddle_pkg::tf_width-1:0] sel_word;

    // Loaded once on reset, read-only afterwards
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            const_mem <= twiddle_pkg::const_init;
        end
    end

    // Each lane looks up its own entry
    always_comb begin
        for (int l = 0; l < twiddle_pkg::tf_lanes; l++) begin
            sel_word[l] = const_mem[const_idx[l]];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_const <= '0;
        end else if (tf_ren) begin
            rd_const <= sel_word;
        end
    end

endmodule

// ==== src/twiddle_pkg.sv ====
package twiddle_pkg;

    localparam int tf_width       = 28;
    localparam int tf_lanes       = 15;
    localparam int tf_depth       = 8;
    localparam int depth_bits     = 3;
    localparam int const_entries  = 16;
    localparam int const_idx_bits = 4;

    // Base twiddle rows at reset, one word per lane
    localparam logic [tf_width-1:0] base_init [tf_depth][tf_lanes] = '{
        '{
            28'h3e3a2b0, 28'h442e7e8, 28'h1cff90a,
            28'h6f76bcb, 28'h19bf5d5, 28'h7dbe285,
            28'h2646f0b, 28'h108822e, 28'h09dbc38,
            28'h698c44d, 28'h7f5e353, 28'h3d22f79,
            28'h259c593, 28'h0e25dd5, 28'h9884296
        },
        '{
            28'h339af8f, 28'h005a761, 28'h1cf41c6,
            28'h1905fdb, 28'h17fc5dd, 28'h120de63,
            28'h9ac3146, 28'h372a390, 28'h7aa4c57,
            28'h1230ae7, 28'h6617b95, 28'h7cdff82,
            28'h68cdd99, 28'h86e7108, 28'h4454f67
        },
        '{
            28'h808a836, 28'h4fc14e6, 28'h4899ee9,
            28'h8fcf14c, 28'h17d1a3e, 28'h2b9bdb3,
            28'h367537e, 28'h280df35, 28'h1debef5,
            28'h6cc01f1, 28'h68a1e5c, 28'h7e0af96,
            28'h4874eb9, 28'h760187e, 28'h66c411f
        },
        '{
            28'h33fe7d2, 28'h0122a49, 28'h8f3339a,
            28'h66fc73b, 28'h4bc73ea, 28'h88a9d60,
            28'h9b086e1, 28'h44f23cb, 28'h963090d,
            28'h78486cd, 28'h044ea3e, 28'h093bab2,
            28'h55189ed, 28'h6fcdb71, 28'h62fa6b8
        },
        '{0: 28'h7b37359, default: '0},   // Only lane 0 is populated
        '{default: '0},
        '{default: '0},
        '{default: '0}
    };

    // Constant twiddles addressed by the per-lane index
    localparam logic [tf_width-1:0] const_init [const_entries] = '{
        28'h7b37359,
        28'h280df35,
        28'h8fcf14c,
        28'h4fc14e6,
        28'h808a836,
        28'h372a390,
        28'h1905fdb,
        28'h005a761,
        28'h339af8f,
        28'h108822e,
        28'h6f76bcb,
        28'h442e7e8,
        28'h3e3a2b0,
        28'h0000001,                      // Unity twiddle
        28'h0000000,
        28'h0000000
    };

endpackage

// ==== src/twiddle_store.sv ====
`timescale 1ns/1ns

module twiddle_store (
    input  logic                                                              clk,
    input  logic                                                              rst,
    input  logic                                                              tf_ren,
    input  logic                                                              tf_wen,
    input  logic [twiddle_pkg::depth_bits-1:0]                                rd_depth,
    input  logic [twiddle_pkg::depth_bits-1:0]                                wr_depth,
    input  logic [twiddle_pkg::tf_lanes-1:0][twiddle_pkg::tf_width-1:0]       wr_base,
    input  logic [twiddle_pkg::tf_lanes-1:0][twiddle_pkg::const_idx_bits-1:0] const_idx,
    output logic [twiddle_pkg::tf_lanes-1:0][twiddle_pkg::tf_width-1:0]       rd_base,
    output logic [twiddle_pkg::tf_lanes-1:0][twiddle_pkg::tf_width-1:0]       rd_const
);

    // Writable base rows
    twiddle_base_bank u_base_bank (
        .clk      (clk),
        .rst      (rst),
        .tf_ren   (tf_ren),
        .tf_wen   (tf_wen),
        .rd_depth (rd_depth),
        .wr_depth (wr_depth),
        .wr_base  (wr_base),
        .rd_base  (rd_base)
    );

    // Shares the read strobe so both outputs line up
    twiddle_const_table u_const_table (
        .clk       (clk),
        .rst       (rst),
        .tf_ren    (tf_ren),
        .const_idx (const_idx),
        .rd_const  (rd_const)
    );

endmodule

// ==== verification/twiddle_store_checks.svh ====
// Per-lane comparison of both read ports against the model
genvar lane;
generate
    for (lane = 0; lane < twiddle_pkg::tf_lanes; lane++) begin : g_lane_chk
        assert property (@(posedge clk) disable iff (rst)
            rd_base[lane] == exp_rd_base[lane])
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t ns: rd_base[%0d] expected %h got %h",
                     $time, lane, $sampled(exp_rd_base[lane]), $sampled(rd_base[lane]));
        end

        assert property (@(posedge clk) disable iff (rst)
            rd_const[lane] == exp_rd_const[lane])
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t ns: rd_const[%0d] expected %h got %h",
                     $time, lane, $sampled(exp_rd_const[lane]), $sampled(rd_const[lane]));
        end
    end
endgenerate

// Both ports come out of reset cleared
assert property (@(posedge clk) disable iff (rst)
    $fell(rst) |-> rd_base == '0)
else begin
    mismatch_count++;
    $display("MISMATCH at %0t ns: rd_base after reset expected %h got %h",
             $time, {twiddle_pkg::tf_lanes * twiddle_pkg::tf_width{1'b0}}, $sampled(rd_base));
end

assert property (@(posedge clk) disable iff (rst)
    $fell(rst) |-> rd_const == '0)
else begin
    mismatch_count++;
    $display("MISMATCH at %0t ns: rd_const after reset expected %h got %h",
             $time, {twiddle_pkg::tf_lanes * twiddle_pkg::tf_width{1'b0}}, $sampled(rd_const));
end

assert property (@(posedge clk) disable iff (rst)
    !$isunknown({rd_base, rd_const}))
else begin
    other_errors++;
    $display("Error at %0t ns: read outputs carry unknown bits", $time);
end

// ==== verification/twiddle_store_tb.sv ====
`timescale 1ns/1ns

module twiddle_store_tb;

    typedef logic [twiddle_pkg::tf_lanes-1:0][twiddle_pkg::tf_width-1:0]       row_t;
    typedef logic [twiddle_pkg::tf_lanes-1:0][twiddle_pkg::const_idx_bits-1:0] idx_t;
    typedef logic [twiddle_pkg::depth_bits-1:0]                                depth_t;

    localparam int clk_period    = 4;
    localparam int reset_cycles  = 5;
    localparam int const_reads   = 48;
    localparam int max_gap       = 3;
    localparam int write_count   = 32;
    localparam int mixed_count   = 64;
    localparam int stim_cycles   = reset_cycles * 2 + 3 * (twiddle_pkg::tf_depth + 2)
                                   + const_reads * (max_gap + 1) + write_count
                                   + mixed_count + 24;
    localparam int margin_cycles = 50;

    logic   clk = 1'b0;
    logic   rst;
    logic   tf_ren;
    logic   tf_wen;
    depth_t rd_depth;
    depth_t wr_depth;
    row_t   wr_base;
    idx_t   const_idx;
    row_t   rd_base;
    row_t   rd_const;

    // Reference model state
    logic [twiddle_pkg::tf_width-1:0] model_mem [twiddle_pkg::tf_depth][twiddle_pkg::tf_lanes];
    row_t exp_rd_base;
    row_t exp_rd_const;

    int mismatch_count = 0;
    int other_errors   = 0;

    twiddle_store DUT (
        .clk       (clk),
        .rst       (rst),
        .tf_ren    (tf_ren),
        .tf_wen    (tf_wen),
        .rd_depth  (rd_depth),
        .wr_depth  (wr_depth),
        .wr_base   (wr_base),
        .const_idx (const_idx),
        .rd_base   (rd_base),
        .rd_const  (rd_const)
    );

    always #2 clk = ~clk;

    `include "twiddle_store_checks.svh"

    // Read sees the row before this edge's write
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            model_mem = twiddle_pkg::base_init;
            exp_rd_base  <= '0;
            exp_rd_const <= '0;
        end else begin
            if (tf_ren) begin
                for (int l = 0; l < twiddle_pkg::tf_lanes; l++) begin
                    exp_rd_base[l]  <= model_mem[rd_depth][l];
                    exp_rd_const[l] <= twiddle_pkg::const_init[const_idx[l]];
                end
            end
            if (tf_wen) begin
                for (int l = 0; l < twiddle_pkg::tf_lanes; l++) begin
                    model_mem[wr_depth][l] = wr_base[l];
                end
            end
        end
    end

    function automatic row_t rand_row();
        row_t        row;
        logic [31:0] r;
        for (int l = 0; l < twiddle_pkg::tf_lanes; l++) begin
            r = $urandom;
            row[l] = r[twiddle_pkg::tf_width-1:0];
        end
        return row;
    endfunction

    function automatic idx_t rand_idx();
        idx_t        idx;
        logic [31:0] r;
        for (int l = 0; l < twiddle_pkg::tf_lanes; l++) begin
            r = $urandom;
            idx[l] = r[twiddle_pkg::const_idx_bits-1:0];
        end
        return idx;
    endfunction

    function automatic depth_t rand_depth();
        logic [31:0] r;
        r = $urandom;
        return r[twiddle_pkg::depth_bits-1:0];
    endfunction

    // One cycle of stimulus, applied at the rising edge
    task automatic drive(input logic ren, input logic wen, input depth_t rdd,
                         input depth_t wrd, input row_t wdata, input idx_t idx);
        @(posedge clk);
        tf_ren    <= ren;
        tf_wen    <= wen;
        rd_depth  <= rdd;
        wr_depth  <= wrd;
        wr_base   <= wdata;
        const_idx <= idx;
    endtask

    task automatic idle();
        drive(1'b0, 1'b0, rand_depth(), rand_depth(), rand_row(), rand_idx());
    endtask

    task automatic read_all_depths();
        depth_t d;
        for (int i = 0; i < twiddle_pkg::tf_depth; i++) begin
            d = i[twiddle_pkg::depth_bits-1:0];
            drive(1'b1, 1'b0, d, rand_depth(), rand_row(), rand_idx());
        end
        idle();
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic finish_run();
        $display("Report: %0d mismatches, %0d other errors", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        depth_t d;
        row_t   row;
        void'($urandom(32'h545ed489));
        rst       <= 1'b1;
        tf_ren    <= 1'b0;
        tf_wen    <= 1'b0;
        rd_depth  <= '0;
        wr_depth  <= '0;
        wr_base   <= '0;
        const_idx <= '0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        idle();                                   // Outputs stay zero after reset
        idle();
        read_all_depths();                        // Reset rows

        repeat (const_reads) begin                // Constant lookups with gaps
            drive(1'b1, 1'b0, rand_depth(), rand_depth(), rand_row(), rand_idx());
            repeat ($urandom_range(max_gap, 0)) idle();
        end

        repeat (write_count) begin
            drive(1'b0, 1'b1, rand_depth(), rand_depth(), rand_row(), rand_idx());
        end
        read_all_depths();

        repeat (mixed_count) begin
            drive($urandom_range(1, 0) == 1, $urandom_range(1, 0) == 1, rand_depth(),
                  rand_depth(), rand_row(), rand_idx());
        end
        idle();

        // Read during write, same row then different rows
        d   = rand_depth();
        row = rand_row();
        drive(1'b1, 1'b1, d, d, row, rand_idx());
        drive(1'b1, 1'b0, d, rand_depth(), rand_row(), rand_idx());
        drive(1'b1, 1'b1, d, d + depth_t'(1), rand_row(), rand_idx());
        drive(1'b1, 1'b0, d + depth_t'(1), rand_depth(), rand_row(), rand_idx());
        idle();

        apply_reset();                            // Written rows return to reset values
        idle();
        read_all_depths();
        idle();
        @(posedge clk);
        finish_run();
    end

    initial begin
        #((stim_cycles + margin_cycles) * clk_period);
        $display("Timeout: stimulus did not complete within %0d ns",
                 (stim_cycles + margin_cycles) * clk_period);
        other_errors++;
        finish_run();
    end

endmodule
